// ==== src/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // One data word
    typedef logic [31:0] xlen_t;
    // CSR address field
    typedef logic [11:0] csr_addr_t;
    // Integer register index
    typedef logic [4:0]  reg_idx_t;
    // Privilege level encoding
    typedef logic [1:0]  priv_t;
    // Decoded operation
    typedef logic [2:0]  csr_op_t;
    // Consumer credit counter, up to 7 outstanding
    typedef logic [2:0]  credit_t;

    // Only U and M are supported
    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_M = 2'd3;

    // Operation codes
    localparam csr_op_t OP_NONE    = 3'd0;
    localparam csr_op_t OP_RW      = 3'd1;
    localparam csr_op_t OP_RS      = 3'd2;
    localparam csr_op_t OP_RC      = 3'd3;
    localparam csr_op_t OP_ECALL   = 3'd4;
    localparam csr_op_t OP_MRET    = 3'd5;
    localparam csr_op_t OP_ILLEGAL = 3'd6;

    // Machine read-write registers
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    // Read-only identity block
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
    // Current privilege, custom read-only slot
    localparam csr_addr_t ADDR_MCURPRIV  = 12'hFC0;

    // Identity values
    localparam xlen_t MVENDORID_VALUE = 32'h0A1AA1E0;
    localparam xlen_t MARCHID_VALUE   = 32'h0000_0001;
    localparam xlen_t MIMPID_VALUE    = 32'h0000_0001;
    localparam xlen_t MHARTID_VALUE   = 32'h0000_0000;

    // Instruction format
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
    localparam xlen_t INSTR_ECALL = 32'h0000_0073;
    localparam xlen_t INSTR_MRET  = 32'h3020_0073;

    // Trap causes
    localparam xlen_t CAUSE_ECALL_U = 32'd8;
    localparam xlen_t CAUSE_ECALL_M = 32'd11;

    // Result queue entries, also the producer's starting credits
    localparam int QUEUE_DEPTH = 4;

    // Queue pointer and occupancy
    typedef logic [$clog2(QUEUE_DEPTH)-1:0]   qptr_t;
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] qcount_t;

    // Request from the producer
    typedef struct packed {
        xlen_t instr;
        xlen_t rs1_value;
        xlen_t pc;
    } sys_req_t;

    // Decode to execute record
    typedef struct packed {
        csr_op_t   op;
        csr_addr_t addr;
        xlen_t     operand;
        reg_idx_t  rd;
        logic      write_en;
        xlen_t     pc;
    } csr_dec_t;

    // Writeback and redirect result
    typedef struct packed {
        reg_idx_t rd;
        xlen_t    rd_data;
        logic     rd_we;
        logic     illegal;
        logic     redirect;
        xlen_t    target;
    } sys_rsp_t;

endpackage

`default_nettype wire

// ==== src/csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_decode
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  sys_req_t req,
    output logic     dec_valid,
    output csr_dec_t dec
);

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1_field;
    csr_dec_t   dec_next;

    always_comb begin
        opcode    = req.instr[6:0];
        funct3    = req.instr[14:12];
        rs1_field = req.instr[19:15];

        // Fields common to every class
        dec_next.op       = OP_NONE;
        dec_next.addr     = req.instr[31:20];
        dec_next.rd       = req.instr[11:7];
        dec_next.write_en = 1'b0;
        dec_next.pc       = req.pc;

        // Immediate forms take zero-extended rs1 field
        if (funct3[2]) begin
            dec_next.operand = {27'd0, rs1_field};
        end else begin
            dec_next.operand = req.rs1_value;
        end

        // Bubbles stay OP_NONE
        if (req_valid) begin
            if (opcode == OPCODE_SYSTEM && funct3[1:0] != 2'b00) begin
                case (funct3[1:0])
                    2'b01: begin
                        // Swap always writes
                        dec_next.op       = OP_RW;
                        dec_next.write_en = 1'b1;
                    end
                    2'b10: begin
                        // Set with x0 or zimm 0 is a pure read
                        dec_next.op       = OP_RS;
                        dec_next.write_en = (rs1_field != '0);
                    end
                    default: begin
                        dec_next.op       = OP_RC;
                        dec_next.write_en = (rs1_field != '0);
                    end
                endcase
            end else if (req.instr == INSTR_ECALL) begin
                dec_next.op = OP_ECALL;
            end else if (req.instr == INSTR_MRET) begin
                dec_next.op = OP_MRET;
            end else begin
                // Non-SYSTEM or unsupported SYSTEM encoding
                dec_next.op = OP_ILLEGAL;
            end
        end
    end

    // Valid flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    // Decoded record, qualified by dec_valid
    always_ff @(posedge clk) begin
        dec <= dec_next;
    end

endmodule

`default_nettype wire

// ==== src/csr_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_execute
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     dec_valid,
    input  csr_dec_t dec,
    output logic     exe_valid,
    output sys_rsp_t exe_rsp
);

    // Architectural state
    priv_t priv;
    priv_t mpp;
    xlen_t mscratch;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;

    // Access evaluation
    xlen_t    old_value;
    xlen_t    new_value;
    logic     addr_known;
    logic     addr_read_only;
    logic     is_csr_op;
    logic     csr_legal;
    logic     csr_write_en;
    logic     is_ecall;
    logic     mret_ok;
    sys_rsp_t rsp_next;

    // Read mux
    always_comb begin
        addr_known = 1'b1;
        case (dec.addr)
            ADDR_MSTATUS:   old_value = {19'd0, mpp, 11'd0};
            ADDR_MTVEC:     old_value = mtvec;
            ADDR_MSCRATCH:  old_value = mscratch;
            ADDR_MEPC:      old_value = mepc;
            ADDR_MCAUSE:    old_value = mcause;
            ADDR_MVENDORID: old_value = MVENDORID_VALUE;
            ADDR_MARCHID:   old_value = MARCHID_VALUE;
            ADDR_MIMPID:    old_value = MIMPID_VALUE;
            ADDR_MHARTID:   old_value = MHARTID_VALUE;
            ADDR_MCURPRIV:  old_value = {30'd0, priv};
            default: begin
                old_value  = '0;
                addr_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        // Top two address bits 11 mark read-only space
        addr_read_only = (dec.addr[11:10] == 2'b11);
        is_csr_op      = (dec.op == OP_RW) || (dec.op == OP_RS) || (dec.op == OP_RC);
        csr_legal      = is_csr_op && (priv == PRIV_M) && addr_known
                         && !(dec.write_en && addr_read_only);
        csr_write_en   = csr_legal && dec.write_en;
        is_ecall       = (dec.op == OP_ECALL);
        // MRET only from M
        mret_ok        = (dec.op == OP_MRET) && (priv == PRIV_M);

        // Write value per operation
        case (dec.op)
            OP_RS:   new_value = old_value | dec.operand;
            OP_RC:   new_value = old_value & ~dec.operand;
            default: new_value = dec.operand;
        endcase

        // Response record
        rsp_next.rd       = dec.rd;
        rsp_next.rd_data  = csr_legal ? old_value : '0;
        rsp_next.rd_we    = csr_legal && (dec.rd != '0);
        rsp_next.illegal  = !(csr_legal || is_ecall || mret_ok);
        rsp_next.redirect = is_ecall || mret_ok;
        if (is_ecall) begin
            rsp_next.target = mtvec;
        end else if (mret_ok) begin
            rsp_next.target = mepc;
        end else begin
            rsp_next.target = '0;
        end
    end

    // State update, only for valid legal work
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv     <= PRIV_M;
            mpp      <= PRIV_U;
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (dec_valid) begin
            if (csr_write_en) begin
                case (dec.addr)
                    ADDR_MSTATUS: begin
                        // WARL, unsupported levels keep old MPP
                        if (new_value[12:11] == PRIV_U || new_value[12:11] == PRIV_M) begin
                            mpp <= new_value[12:11];
                        end
                    end
                    ADDR_MTVEC:    mtvec    <= {new_value[31:2], 2'b00};
                    ADDR_MSCRATCH: mscratch <= new_value;
                    ADDR_MEPC:     mepc     <= {new_value[31:2], 2'b00};
                    ADDR_MCAUSE:   mcause   <= new_value;
                    default: ;
                endcase
            end
            if (is_ecall) begin
                // Trap into M
                mepc   <= dec.pc;
                mcause <= (priv == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
                mpp    <= priv;
                priv   <= PRIV_M;
            end
            if (mret_ok) begin
                // Return to saved level
                priv <= mpp;
                mpp  <= PRIV_U;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        exe_rsp <= rsp_next;
    end

endmodule

`default_nettype wire

// ==== src/csr_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_result
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     exe_valid,
    input  sys_rsp_t exe_rsp,
    input  logic     rsp_credit,
    output logic     rsp_valid,
    output sys_rsp_t rsp,
    output logic     req_credit
);

    // In-order response storage
    sys_rsp_t queue_mem [QUEUE_DEPTH];
    qptr_t    wr_ptr;
    qptr_t    rd_ptr;
    qcount_t  count;
    // Consumer credits held
    credit_t  credits;

    logic     head_avail;
    logic     send;
    sys_rsp_t head;

    always_comb begin
        // Empty queue lets an arriving response go straight out
        head_avail = (count != '0) || exe_valid;
        send       = head_avail && (credits != '0);
        head       = (count != '0) ? queue_mem[rd_ptr] : exe_rsp;
    end

    // Storage, written on every arrival
    always_ff @(posedge clk) begin
        if (exe_valid) begin
            queue_mem[wr_ptr] <= exe_rsp;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (exe_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + qcount_t'(exe_valid) - qcount_t'(send);
        end
    end

    // Credit counter, grant and spend may coincide
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= '0;
        end else begin
            credits <= credits + credit_t'(rsp_credit) - credit_t'(send);
        end
    end

    // One-cycle pulses, producer credit alongside each result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid  <= 1'b0;
            req_credit <= 1'b0;
        end else begin
            rsp_valid  <= send;
            req_credit <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            rsp <= head;
        end
    end

endmodule

`default_nettype wire

// ==== src/csr_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  sys_req_t req,
    output logic     req_credit,
    output logic     rsp_valid,
    output sys_rsp_t rsp,
    input  logic     rsp_credit
);

    // Decode to execute
    logic     dec_valid;
    csr_dec_t dec;
    // Execute to result
    logic     exe_valid;
    sys_rsp_t exe_rsp;

    csr_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    csr_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .exe_valid (exe_valid),
        .exe_rsp   (exe_rsp)
    );

    // Queue and both credit directions
    csr_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .exe_valid  (exe_valid),
        .exe_rsp    (exe_rsp),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .req_credit (req_credit)
    );

endmodule

`default_nettype wire

// ==== verification/csr_unit_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_sva
    import csr_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    exe_valid,
    input logic    rsp_valid,
    input logic    req_credit,
    input credit_t credits,
    input qcount_t count
);

    // Number of failed assertions so far
    int error_count = 0;

    // Result pulse launched only while a consumer credit was held
    a_rsp_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> ($past(credits) != '0))
    else begin
        error_count++;
        $error("rsp_valid issued with no consumer credit held");
    end

    // Producer credit returns alongside every result
    a_credit_with_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        req_credit == rsp_valid)
    else begin
        error_count++;
        $error("req_credit and rsp_valid out of step");
    end

    // Producer credits must keep the queue from overflowing
    a_no_enqueue_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(exe_valid && (count == qcount_t'(QUEUE_DEPTH))))
    else begin
        error_count++;
        $error("response arrived while the queue was full");
    end

endmodule

// Attach to every result stage instance
bind csr_result csr_unit_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .exe_valid  (exe_valid),
    .rsp_valid  (rsp_valid),
    .req_credit (req_credit),
    .credits    (credits),
    .count      (count)
);

`default_nettype wire

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
();

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    sys_req_t req;
    logic     req_credit;
    logic     rsp_valid;
    sys_rsp_t rsp;
    logic     rsp_credit;

    // Producer side bookkeeping
    int       prod_credits = QUEUE_DEPTH;
    int       rsp_seen;
    int       credit_seen;
    int       cycle_count;
    xlen_t    pc_next;
    logic [31:0] lfsr;
    sys_rsp_t rsp_q [$];

    // Expected architectural state
    priv_t m_priv;
    priv_t m_mpp;
    xlen_t m_mscratch;
    xlen_t m_mtvec;
    xlen_t m_mepc;
    xlen_t m_mcause;

    csr_unit_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    always #50 clk = ~clk;

    // Outputs are registered, so posedge sees the settled values
    always @(posedge clk) begin
        if (rst_n) begin
            if (rsp_valid) begin
                rsp_q.push_back(rsp);
                rsp_seen++;
            end
            if (req_credit) begin
                prod_credits++;
                credit_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= 2000) begin
            $display("Timeout: no progress from the DUT after %0d cycles", cycle_count);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // Credit and handshake rules in the result stage
    always @(negedge clk) begin
        if (u_dut.u_result.u_sva.error_count != 0) begin
            $display("Credit or handshake assertion failed in the result stage");
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic xlen_t random_bits(input int n);
        xlen_t value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic xlen_t csr_instr(input logic [2:0] funct3, input csr_addr_t addr,
                                        input reg_idx_t rs1, input reg_idx_t rd);
        return {addr, rs1, funct3, rd, OPCODE_SYSTEM};
    endfunction

    // Reference model, returns expected response and advances state
    function automatic sys_rsp_t model_exec(input xlen_t instr, input xlen_t rs1_value,
                                            input xlen_t pc);
        sys_rsp_t   exp;
        logic [2:0] f3;
        reg_idx_t   rs1;
        csr_addr_t  addr;
        xlen_t      operand;
        xlen_t      old_val;
        xlen_t      new_val;
        logic       known;
        logic       ro;
        logic       we;
        f3       = instr[14:12];
        rs1      = instr[19:15];
        addr     = instr[31:20];
        exp      = '0;
        exp.rd   = instr[11:7];
        if (instr[6:0] == OPCODE_SYSTEM && f3[1:0] != 2'b00) begin
            operand = f3[2] ? xlen_t'(rs1) : rs1_value;
            we      = (f3[1:0] == 2'b01) || (rs1 != 5'd0);
            known   = 1'b1;
            ro      = 1'b1;
            case (addr)
                ADDR_MVENDORID: old_val = 32'h0A1AA1E0;
                ADDR_MARCHID:   old_val = 32'd1;
                ADDR_MIMPID:    old_val = 32'd1;
                ADDR_MHARTID:   old_val = 32'd0;
                ADDR_MCURPRIV:  old_val = xlen_t'(m_priv);
                default: begin
                    ro = 1'b0;
                    case (addr)
                        ADDR_MSTATUS:  old_val = xlen_t'(m_mpp) << 11;
                        ADDR_MTVEC:    old_val = m_mtvec;
                        ADDR_MSCRATCH: old_val = m_mscratch;
                        ADDR_MEPC:     old_val = m_mepc;
                        ADDR_MCAUSE:   old_val = m_mcause;
                        default: begin
                            old_val = '0;
                            known   = 1'b0;
                        end
                    endcase
                end
            endcase
            exp.illegal = !((m_priv == PRIV_M) && known && !(we && ro));
            if (!exp.illegal) begin
                exp.rd_data = old_val;
                exp.rd_we   = (exp.rd != 5'd0);
                if (f3[1:0] == 2'b01) begin
                    new_val = operand;
                end else if (f3[1:0] == 2'b10) begin
                    new_val = old_val | operand;
                end else begin
                    new_val = old_val & ~operand;
                end
                if (we) begin
                    case (addr)
                        ADDR_MSTATUS: begin
                            if (new_val[12:11] == PRIV_U || new_val[12:11] == PRIV_M) begin
                                m_mpp = new_val[12:11];
                            end
                        end
                        ADDR_MTVEC:    m_mtvec    = new_val & ~32'd3;
                        ADDR_MSCRATCH: m_mscratch = new_val;
                        ADDR_MEPC:     m_mepc     = new_val & ~32'd3;
                        ADDR_MCAUSE:   m_mcause   = new_val;
                        default: ;
                    endcase
                end
            end
        end else if (instr == INSTR_ECALL) begin
            exp.redirect = 1'b1;
            exp.target   = m_mtvec;
            m_mepc       = pc;
            m_mcause     = (m_priv == PRIV_U) ? 32'd8 : 32'd11;
            m_mpp        = m_priv;
            m_priv       = PRIV_M;
        end else if (instr == INSTR_MRET && m_priv == PRIV_M) begin
            exp.redirect = 1'b1;
            exp.target   = m_mepc;
            m_priv       = m_mpp;
            m_mpp        = PRIV_U;
        end else begin
            exp.illegal = 1'b1;
        end
        return exp;
    endfunction

    task automatic compare_rsp(input sys_rsp_t exp, input sys_rsp_t act);
        check_value("rsp.illegal", exp.illegal, act.illegal);
        check_value("rsp.rd_we", exp.rd_we, act.rd_we);
        check_value("rsp.redirect", exp.redirect, act.redirect);
        // Old value comes back for any legal CSR access
        if (!exp.illegal && !exp.redirect) begin
            check_value("rsp.rd_data", exp.rd_data, act.rd_data);
        end
        if (exp.rd_we) begin
            check_value("rsp.rd", exp.rd, act.rd);
        end
        if (exp.redirect) begin
            check_value("rsp.target", exp.target, act.target);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_req(input xlen_t instr, input xlen_t rs1_value, input xlen_t pc);
        while (prod_credits == 0) begin
            @(negedge clk);
        end
        req_valid     = 1'b1;
        req.instr     = instr;
        req.rs1_value = rs1_value;
        req.pc        = pc;
        prod_credits--;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Grant n credits, then wait for n results in the queue
    task automatic collect(input int n);
        for (int i = 0; i < n; i++) begin
            rsp_credit = 1'b1;
            @(negedge clk);
        end
        rsp_credit = 1'b0;
        while (rsp_q.size() < n) begin
            @(negedge clk);
        end
    endtask

    task automatic run_op(input xlen_t instr, input xlen_t rs1_value, output sys_rsp_t act);
        sys_rsp_t exp;
        exp = model_exec(instr, rs1_value, pc_next);
        send_req(instr, rs1_value, pc_next);
        pc_next += 4;
        collect(1);
        act = rsp_q.pop_front();
        compare_rsp(exp, act);
    endtask

    task automatic test_reset_reads();
        sys_rsp_t r;
        run_op(csr_instr(3'b010, ADDR_MVENDORID, 5'd0, 5'd5), '0, r);
        check_value("mvendorid", 32'h0A1AA1E0, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MARCHID, 5'd0, 5'd5), '0, r);
        check_value("marchid", 32'd1, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MIMPID, 5'd0, 5'd5), '0, r);
        check_value("mimpid", 32'd1, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MHARTID, 5'd0, 5'd5), '0, r);
        check_value("mhartid", 32'd0, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MCURPRIV, 5'd0, 5'd5), '0, r);
        check_value("mcurpriv", 32'd3, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MSCRATCH, 5'd0, 5'd5), '0, r);
        check_value("mscratch", 32'd0, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MEPC, 5'd0, 5'd5), '0, r);
        check_value("mepc", 32'd0, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MTVEC, 5'd0, 5'd5), '0, r);
        check_value("mtvec", 32'd0, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MCAUSE, 5'd0, 5'd5), '0, r);
        check_value("mcause", 32'd0, r.rd_data);
    endtask

    task automatic test_csr_ops();
        csr_addr_t  regs [3];
        logic [2:0] f3s [6];
        sys_rsp_t   r;
        reg_idx_t   rs1;
        reg_idx_t   rd;
        regs = '{ADDR_MSCRATCH, ADDR_MTVEC, ADDR_MEPC};
        // RW RS RC then the immediate forms
        f3s  = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
        foreach (regs[i]) begin
            foreach (f3s[j]) begin
                rs1 = reg_idx_t'(random_bits(5));
                rd  = reg_idx_t'(random_bits(5));
                run_op(csr_instr(f3s[j], regs[i], rs1, rd), random_bits(32), r);
            end
            // Write still happens, writeback suppressed
            run_op(csr_instr(3'b001, regs[i], 5'd1, 5'd0), random_bits(32), r);
            check_value("rd_we for rd 0", 32'd0, r.rd_we);
            run_op(csr_instr(3'b010, regs[i], 5'd0, 5'd2), '0, r);
        end
    endtask

    task automatic test_illegal();
        sys_rsp_t r;
        run_op(csr_instr(3'b001, ADDR_MVENDORID, 5'd3, 5'd3), random_bits(32), r);
        run_op(csr_instr(3'b010, ADDR_MARCHID, 5'd1, 5'd3), random_bits(32), r);
        run_op(csr_instr(3'b101, ADDR_MCURPRIV, 5'd4, 5'd3), '0, r);
        check_value("read-only write illegal", 32'd1, r.illegal);
        // Unknown addresses, even pure reads
        run_op(csr_instr(3'b010, 12'h7C0, 5'd0, 5'd3), '0, r);
        run_op(csr_instr(3'b001, 12'h123, 5'd6, 5'd3), random_bits(32), r);
        check_value("unknown address illegal", 32'd1, r.illegal);
        // ADDI x0 x0 0
        run_op(32'h0000_0013, '0, r);
        check_value("non-SYSTEM illegal", 32'd1, r.illegal);
        run_op(csr_instr(3'b010, ADDR_MSCRATCH, 5'd0, 5'd3), '0, r);
        run_op(csr_instr(3'b010, ADDR_MHARTID, 5'd0, 5'd3), '0, r);
        check_value("read of read-only legal", 32'd0, r.illegal);
    endtask

    task automatic test_traps();
        sys_rsp_t r;
        xlen_t    ecall_pc;
        run_op(csr_instr(3'b001, ADDR_MTVEC, 5'd1, 5'd0), random_bits(32), r);
        run_op(csr_instr(3'b001, ADDR_MEPC, 5'd1, 5'd0), random_bits(32), r);
        run_op(INSTR_MRET, '0, r);
        // Now in U, reads and MRET trap as illegal
        run_op(csr_instr(3'b010, ADDR_MCURPRIV, 5'd0, 5'd4), '0, r);
        check_value("U-mode read illegal", 32'd1, r.illegal);
        run_op(INSTR_MRET, '0, r);
        check_value("U-mode mret illegal", 32'd1, r.illegal);
        ecall_pc = pc_next;
        run_op(INSTR_ECALL, '0, r);
        run_op(csr_instr(3'b010, ADDR_MEPC, 5'd0, 5'd4), '0, r);
        check_value("mepc after ecall", ecall_pc, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MCAUSE, 5'd0, 5'd4), '0, r);
        check_value("mcause after ecall", 32'd8, r.rd_data);
        run_op(csr_instr(3'b010, ADDR_MSTATUS, 5'd0, 5'd4), '0, r);
        check_value("mstatus.mpp", 32'd0, r.rd_data[12:11]);
        run_op(csr_instr(3'b010, ADDR_MCURPRIV, 5'd0, 5'd4), '0, r);
        check_value("mcurpriv after ecall", 32'd3, r.rd_data);
    endtask

    task automatic test_credit_flow();
        sys_rsp_t exp_q [$];
        sys_rsp_t act;
        xlen_t    data;
        int       base_rsp;
        int       base_credit;
        base_rsp    = rsp_seen;
        base_credit = credit_seen;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            data = random_bits(32);
            exp_q.push_back(model_exec(csr_instr(3'b001, ADDR_MSCRATCH, 5'd7,
                                                 reg_idx_t'(i + 1)), data, pc_next));
            send_req(csr_instr(3'b001, ADDR_MSCRATCH, 5'd7, reg_idx_t'(i + 1)), data, pc_next);
            pc_next += 4;
        end
        // Let the pipeline drain into the queue
        repeat (8) @(negedge clk);
        check_value("results without credit", base_rsp, rsp_seen);
        check_value("req_credit without credit", base_credit, credit_seen);
        check_value("producer credits", 32'd0, prod_credits);
        for (int k = 1; k <= QUEUE_DEPTH; k++) begin
            collect(1);
            repeat (3) @(negedge clk);
            check_value("results per credit", base_rsp + k, rsp_seen);
            check_value("req_credit pulses", base_credit + k, credit_seen);
            act = rsp_q.pop_front();
            compare_rsp(exp_q.pop_front(), act);
        end
        check_value("producer credits returned", QUEUE_DEPTH, prod_credits);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_credit = 1'b0;
        lfsr       = 32'd91522;
        pc_next    = 32'h0000_1000;
        m_priv     = PRIV_M;
        m_mpp      = PRIV_U;
        m_mscratch = '0;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_reads();
        test_csr_ops();
        test_illegal();
        test_traps();
        test_credit_flow();
        if (u_dut.u_result.u_sva.error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/csr_pkg.sv
src/csr_decode.sv
src/csr_execute.sv
src/csr_result.sv
src/csr_unit_top.sv
verification/csr_unit_sva.sv
verification/csr_unit_tb.sv
